//--- sources.f
+incdir+.
na_pkg.sv
noc_buffer.sv
mp_endpoint.sv
na_ctrl.sv
networkadapter_ct.sv
tb_networkadapter_ct.sv

//--- Bender.yml
package:
  name: networkadapter_ct

sources:
  - na_pkg.sv
  - noc_buffer.sv
  - mp_endpoint.sv
  - na_ctrl.sv
  - networkadapter_ct.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_networkadapter_ct.sv

//--- tb_na_tasks.svh
`ifndef TB_NA_TASKS_SVH
`define TB_NA_TASKS_SVH

function automatic logic [23:0] mp_addr(input int c, input logic [3:0] off);
  return 24'h100000 | (24'(c) << 4) | 24'(off);
endfunction

// Oldest entry of channel c, or -1
function automatic int first_for(input logic [W+1:0] q[$], input int c);
  for (int i = 0; i < q.size(); i++) begin
    if (q[i][W+1] == c[0]) begin
      return i;
    end
  end
  return -1;
endfunction

task automatic check_value(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
  assert (got === exp) else begin
    mism_cnt++;
    $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
  end
endtask

task automatic bus_access(input logic [23:0] adr, input logic we, input logic [W-1:0] wdat,
                          input logic exp_err, output logic [W-1:0] rdat, output logic err);
  int lat;
  @(posedge clk);
  #1;
  wbs_adr_i = adr;
  wbs_dat_i = wdat;
  wbs_we_i  = we;
  wbs_cyc_i = 1'b1;
  wbs_stb_i = 1'b1;
  // Request is sampled on this edge
  @(posedge clk);
  lat = 0;
  do begin
    @(negedge clk);
    lat++;
  end while (!(wbs_ack_o || wbs_err_o) && lat < 8);
  if (!(wbs_ack_o || wbs_err_o)) begin
    fail_cnt++;
    $display("Bus access to address %h got neither ack nor err at %0t", adr, $time);
  end
  check_value("bus response latency", lat, 1);
  check_value("wbs_err_o", wbs_err_o, exp_err);
  check_value("wbs_ack_o", wbs_ack_o, !exp_err);
  rdat = wbs_dat_o;
  err  = wbs_err_o;
  @(posedge clk);
  #1;
  wbs_cyc_i = 1'b0;
  wbs_stb_i = 1'b0;
  wbs_we_i  = 1'b0;
endtask

task automatic bus_write(input logic [23:0] adr, input logic [W-1:0] dat, input logic exp_err);
  logic [W-1:0] rd;
  logic         err;
  bus_access(adr, 1'b1, dat, exp_err, rd, err);
endtask

task automatic bus_read(input logic [23:0] adr, output logic [W-1:0] rdat);
  logic err;
  bus_access(adr, 1'b0, '0, 1'b0, rdat, err);
endtask

task automatic send_flit(input int c, input logic [W-1:0] dat, input logic last,
                         input logic exp_err);
  logic [W-1:0] rd;
  logic         err;
  bus_access(mp_addr(c, last ? na_pkg::MP_SEND_LAST : na_pkg::MP_SEND), 1'b1, dat, exp_err,
             rd, err);
  if (!err) begin
    exp_out.push_back({c[0], last, dat});
    if (last) begin
      out_pend[c]++;
    end
  end
endtask

task automatic drive_noc_packet(input int c, input int len);
  logic [W-1:0] dat;
  logic         last;
  logic         taken;
  @(posedge clk);
  #1;
  for (int i = 0; i < len; i++) begin
    dat  = $urandom;
    last = (i == len - 1);
    noc_in_flit_i[c]  = dat;
    noc_in_last_i[c]  = last;
    noc_in_valid_i[c] = 1'b1;
    do begin
      @(negedge clk);
      taken = noc_in_ready_o[c];
      @(posedge clk);
    end while (!taken);
    exp_in.push_back({c[0], last, dat});
    #1;
  end
  noc_in_valid_i[c] = 1'b0;
endtask

task automatic wait_packet(input int c, output int count);
  logic [W-1:0] st;
  int           polls;
  polls = 0;
  do begin
    bus_read(mp_addr(c, na_pkg::MP_STATUS), st);
    polls++;
  end while (st[7:0] == 8'd0 && polls < 100);
  if (st[7:0] == 8'd0) begin
    fail_cnt++;
    $display("No complete packet arrived on channel %0d by %0t", c, $time);
  end
  count = st[7:0];
endtask

task automatic read_packet(input int c);
  logic [W-1:0] st;
  logic [W-1:0] dat;
  logic         last;
  int           idx;
  int           count;
  wait_packet(c, count);
  last = (count == 0);
  while (!last) begin
    idx = first_for(exp_in, c);
    if (idx < 0) begin
      fail_cnt++;
      $display("Channel %0d reports a packet that was never sent at %0t", c, $time);
      return;
    end
    bus_read(mp_addr(c, na_pkg::MP_STATUS), st);
    check_value("MP_STATUS last flag", st[31], exp_in[idx][W]);
    bus_read(mp_addr(c, na_pkg::MP_RECV), dat);
    check_value("MP_RECV flit", dat, exp_in[idx][W-1:0]);
    last = exp_in[idx][W];
    exp_in.delete(idx);
  end
endtask

task automatic take_out_flit(input int c, input logic [W-1:0] flit, input logic last);
  int idx;
  idx = first_for(exp_out, c);
  if (idx < 0) begin
    fail_cnt++;
    $display("Unexpected flit %h on noc_out channel %0d at %0t", flit, c, $time);
  end else begin
    check_value($sformatf("noc_out_flit_o[%0d]", c), flit, exp_out[idx][W-1:0]);
    check_value($sformatf("noc_out_last_o[%0d]", c), last, exp_out[idx][W]);
    if (exp_out[idx][W]) begin
      out_pend[c]--;
    end
    exp_out.delete(idx);
  end
endtask

task automatic wait_out_drained(input int c);
  int n;
  n = 0;
  while (first_for(exp_out, c) >= 0 && n < 200) begin
    @(negedge clk);
    n++;
  end
  if (first_for(exp_out, c) >= 0) begin
    fail_cnt++;
    $display("Flits written to channel %0d never left noc_out by %0t", c, $time);
  end
endtask

`endif

//--- tb_networkadapter_ct.sv
`timescale 1ns/1ps

module tb_networkadapter_ct;

  localparam int CLK_PERIOD  = 4;
  // About 2500 cycles of traffic in all six tests, doubled for margin
  localparam int TEST_CYCLES = 2500;
  localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 2;
  localparam int W           = na_pkg::FLIT_WIDTH;

  logic                  clk;
  logic                  arst_n_i;
  logic [1:0][W-1:0]     noc_in_flit_i;
  logic [1:0]            noc_in_last_i;
  logic [1:0]            noc_in_valid_i;
  logic [1:0]            noc_in_ready_o;
  logic [1:0][W-1:0]     noc_out_flit_o;
  logic [1:0]            noc_out_last_o;
  logic [1:0]            noc_out_valid_o;
  logic [1:0]            noc_out_ready_i;
  logic [23:0]           wbs_adr_i;
  logic [W-1:0]          wbs_dat_i;
  logic                  wbs_cyc_i;
  logic                  wbs_stb_i;
  logic                  wbs_we_i;
  logic [W-1:0]          wbs_dat_o;
  logic                  wbs_ack_o;
  logic                  wbs_err_o;
  logic [1:0]            irq_o;

  int                    mism_cnt;
  int                    fail_cnt;
  // Expected flits as {channel, last, flit}
  logic [W+1:0]          exp_out[$];
  logic [W+1:0]          exp_in[$];
  // Complete packets acked on the bus and not yet out on the NoC
  int                    out_pend [na_pkg::CHANNELS];

  `include "tb_na_tasks.svh"

  networkadapter_ct networkadapter_ct_inst (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  assert property (@(posedge clk) disable iff (!arst_n_i) !(wbs_ack_o && wbs_err_o))
    else begin
      fail_cnt++;
      $display("Bus ack and err were high together at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!arst_n_i)
    (wbs_ack_o || wbs_err_o) |=> !(wbs_ack_o || wbs_err_o))
    else begin
      fail_cnt++;
      $display("Bus response lasted more than one cycle at %0t", $time);
    end

  // NoC sink models
  for (genvar c = 0; c < na_pkg::CHANNELS; c++) begin : g_noc_out
    always @(negedge clk) begin
      if (arst_n_i && noc_out_valid_o[c]) begin
        assert (out_pend[c] != 0) else begin
          fail_cnt++;
          $display("Channel %0d offered a flit of an unfinished packet at %0t", c, $time);
        end
        if (noc_out_ready_i[c]) begin
          take_out_flit(c, noc_out_flit_o[c], noc_out_last_o[c]);
        end
      end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i)
      noc_out_valid_o[c] && !noc_out_ready_i[c] |=>
        noc_out_valid_o[c] && $stable(noc_out_flit_o[c]) && $stable(noc_out_last_o[c]))
      else begin
        fail_cnt++;
        $display("Channel %0d output flit changed while stalled at %0t", c, $time);
      end
  end

  initial begin
    logic [W-1:0] rd;
    int           count;
    int           len0;
    int           len1;
    void'($urandom(63));
    mism_cnt        = 0;
    fail_cnt        = 0;
    out_pend        = '{0, 0};
    arst_n_i        = 1'b0;
    noc_in_flit_i   = '0;
    noc_in_last_i   = '0;
    noc_in_valid_i  = '0;
    noc_out_ready_i = 2'b11;
    wbs_adr_i       = '0;
    wbs_dat_i       = '0;
    wbs_cyc_i       = 1'b0;
    wbs_stb_i       = 1'b0;
    wbs_we_i        = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk);
    check_value("wbs_ack_o", wbs_ack_o, 0);
    check_value("wbs_err_o", wbs_err_o, 0);
    check_value("noc_out_valid_o", noc_out_valid_o, 0);
    check_value("irq_o", irq_o, 0);
    check_value("noc_in_ready_o", noc_in_ready_o, 2'b11);

    // Configuration registers
    bus_read(24'(na_pkg::CONF_TILEID), rd);
    check_value("CONF_TILEID", rd, 5);
    bus_read(24'(na_pkg::CONF_NCHANNELS), rd);
    check_value("CONF_NCHANNELS", rd, 2);
    bus_read(24'(na_pkg::CONF_IRQEN), rd);
    check_value("CONF_IRQEN", rd, 0);
    bus_write(24'(na_pkg::CONF_IRQEN), 2, 1'b0);
    bus_read(24'(na_pkg::CONF_IRQEN), rd);
    check_value("CONF_IRQEN", rd, 2);
    bus_write(24'(na_pkg::CONF_IRQEN), 0, 1'b0);

    // Send path, each packet held briefly at a stalled output
    for (int c = 0; c < 2; c++) begin
      len0 = $urandom_range(6, 1);
      @(posedge clk);
      #1;
      noc_out_ready_i[c] = 1'b0;
      for (int i = 0; i < len0; i++) begin
        send_flit(c, $urandom, i == len0 - 1, 1'b0);
      end
      wait (noc_out_valid_o[c]);
      @(posedge clk);
      #1;
      noc_out_ready_i[c] = 1'b1;
      wait_out_drained(c);
    end

    // Receive path and interrupt
    for (int c = 0; c < 2; c++) begin
      bus_write(24'(na_pkg::CONF_IRQEN), 3, 1'b0);
      drive_noc_packet(c, $urandom_range(6, 1));
      wait_packet(c, count);
      check_value("MP_STATUS packet count", count, 1);
      @(negedge clk);
      check_value("irq_o", irq_o, 2'b01 << c);
      bus_write(24'(na_pkg::CONF_IRQEN), 0, 1'b0);
      @(negedge clk);
      check_value("irq_o", irq_o, 0);
      bus_write(24'(na_pkg::CONF_IRQEN), 3, 1'b0);
      read_packet(c);
      repeat (2) @(negedge clk);
      check_value("irq_o", irq_o, 0);
    end

    // One-flit packets into a stalled output until the send queue is full
    @(posedge clk);
    #1;
    noc_out_ready_i[0] = 1'b0;
    for (int i = 0; i < 24; i++) begin
      send_flit(0, $urandom, 1'b1, i >= na_pkg::BUF_DEPTH + na_pkg::MP_DEPTH);
    end
    noc_out_ready_i[0] = 1'b1;
    wait_out_drained(0);

    // Input back-pressure
    fork
      for (int k = 0; k < 5; k++) begin
        drive_noc_packet(1, 5);
      end
    join_none
    count = 0;
    while (noc_in_ready_o[1] && count < 200) begin
      @(negedge clk);
      count++;
    end
    check_value("noc_in_ready_o[1]", noc_in_ready_o[1], 0);
    for (int k = 0; k < 5; k++) begin
      read_packet(1);
    end
    @(negedge clk);
    check_value("noc_in_ready_o[1]", noc_in_ready_o[1], 1);

    // Illegal accesses
    bus_write(24'h200000, 32'h1, 1'b1);
    bus_access(24'hF00004, 1'b0, '0, 1'b1, rd, count[0]);
    bus_write(24'(na_pkg::CONF_TILEID), 32'h7, 1'b1);
    bus_write(24'(na_pkg::CONF_NCHANNELS), 32'h7, 1'b1);
    bus_write(mp_addr(1, na_pkg::MP_STATUS), 32'h7, 1'b1);
    bus_access(mp_addr(0, na_pkg::MP_RECV), 1'b0, '0, 1'b1, rd, count[0]);
    for (int c = 0; c < 2; c++) begin
      bus_read(mp_addr(c, na_pkg::MP_STATUS), rd);
      check_value("MP_STATUS packet count", rd[7:0], 0);
    end

    // Both channels in both directions at once
    fork
      begin
        drive_noc_packet(0, $urandom_range(6, 1));
        drive_noc_packet(0, $urandom_range(6, 1));
      end
      begin
        drive_noc_packet(1, $urandom_range(6, 1));
        drive_noc_packet(1, $urandom_range(6, 1));
      end
      for (int r = 0; r < 2; r++) begin
        len0 = $urandom_range(6, 1);
        len1 = $urandom_range(6, 1);
        for (int i = 0; i < 6; i++) begin
          if (i < len0) send_flit(0, $urandom, i == len0 - 1, 1'b0);
          if (i < len1) send_flit(1, $urandom, i == len1 - 1, 1'b0);
        end
      end
    join
    for (int k = 0; k < 4; k++) begin
      read_packet(k % 2);
    end
    wait_out_drained(0);
    wait_out_drained(1);
    check_value("leftover noc_in flits", exp_in.size(), 0);

    repeat (4) @(negedge clk);
    $display("Error counts: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run was still going after %0d ns", WATCHDOG_NS);
    $display("Error counts: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- networkadapter_ct.sv
`timescale 1ns/1ps

module networkadapter_ct (
  input  logic                                                clk,
  input  logic                                                arst_n_i,

  input  logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] noc_in_flit_i,
  input  logic [na_pkg::CHANNELS-1:0]                         noc_in_last_i,
  input  logic [na_pkg::CHANNELS-1:0]                         noc_in_valid_i,
  output logic [na_pkg::CHANNELS-1:0]                         noc_in_ready_o,

  output logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] noc_out_flit_o,
  output logic [na_pkg::CHANNELS-1:0]                         noc_out_last_o,
  output logic [na_pkg::CHANNELS-1:0]                         noc_out_valid_o,
  input  logic [na_pkg::CHANNELS-1:0]                         noc_out_ready_i,

  input  logic [na_pkg::ADDR_WIDTH-1:0]                       wbs_adr_i,
  input  logic [na_pkg::FLIT_WIDTH-1:0]                       wbs_dat_i,
  input  logic                                                wbs_cyc_i,
  input  logic                                                wbs_stb_i,
  input  logic                                                wbs_we_i,
  output logic [na_pkg::FLIT_WIDTH-1:0]                       wbs_dat_o,
  output logic                                                wbs_ack_o,
  output logic                                                wbs_err_o,

  output logic [na_pkg::CHANNELS-1:0]                         irq_o
);

  logic [na_pkg::CHANNELS-1:0]                         send_push;
  logic [na_pkg::CHANNELS-1:0]                         send_last;
  logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] send_flit;
  logic [na_pkg::CHANNELS-1:0]                         send_full;
  logic [na_pkg::CHANNELS-1:0]                         recv_pop;
  logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] recv_flit;
  logic [na_pkg::CHANNELS-1:0]                         recv_last;
  logic [na_pkg::CHANNELS-1:0]                         recv_empty;
  logic [na_pkg::CHANNELS-1:0][na_pkg::MP_CNT_W-1:0]   pkt_count;

  // Endpoint side of the NoC buffers
  logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] ep_out_flit;
  logic [na_pkg::CHANNELS-1:0]                         ep_out_last;
  logic [na_pkg::CHANNELS-1:0]                         ep_out_valid;
  logic [na_pkg::CHANNELS-1:0]                         ep_out_ready;
  logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] ep_in_flit;
  logic [na_pkg::CHANNELS-1:0]                         ep_in_last;
  logic [na_pkg::CHANNELS-1:0]                         ep_in_valid;
  logic [na_pkg::CHANNELS-1:0]                         ep_in_ready;

  na_ctrl u_ctrl (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wbs_adr_i    (wbs_adr_i),
    .wbs_dat_i    (wbs_dat_i),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_we_i     (wbs_we_i),
    .wbs_dat_o    (wbs_dat_o),
    .wbs_ack_o    (wbs_ack_o),
    .wbs_err_o    (wbs_err_o),
    .send_push_o  (send_push),
    .send_last_o  (send_last),
    .send_flit_o  (send_flit),
    .recv_pop_o   (recv_pop),
    .send_full_i  (send_full),
    .recv_flit_i  (recv_flit),
    .recv_last_i  (recv_last),
    .recv_empty_i (recv_empty),
    .pkt_count_i  (pkt_count),
    .irq_o        (irq_o)
  );

  // Request channel
  mp_endpoint u_ep0 (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .send_push_i     (send_push[0]),
    .send_last_i     (send_last[0]),
    .send_flit_i     (send_flit[0]),
    .send_full_o     (send_full[0]),
    .recv_pop_i      (recv_pop[0]),
    .recv_flit_o     (recv_flit[0]),
    .recv_last_o     (recv_last[0]),
    .recv_empty_o    (recv_empty[0]),
    .pkt_count_o     (pkt_count[0]),
    .noc_out_flit_o  (ep_out_flit[0]),
    .noc_out_last_o  (ep_out_last[0]),
    .noc_out_valid_o (ep_out_valid[0]),
    .noc_out_ready_i (ep_out_ready[0]),
    .noc_in_flit_i   (ep_in_flit[0]),
    .noc_in_last_i   (ep_in_last[0]),
    .noc_in_valid_i  (ep_in_valid[0]),
    .noc_in_ready_o  (ep_in_ready[0])
  );

  // Response channel
  mp_endpoint u_ep1 (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .send_push_i     (send_push[1]),
    .send_last_i     (send_last[1]),
    .send_flit_i     (send_flit[1]),
    .send_full_o     (send_full[1]),
    .recv_pop_i      (recv_pop[1]),
    .recv_flit_o     (recv_flit[1]),
    .recv_last_o     (recv_last[1]),
    .recv_empty_o    (recv_empty[1]),
    .pkt_count_o     (pkt_count[1]),
    .noc_out_flit_o  (ep_out_flit[1]),
    .noc_out_last_o  (ep_out_last[1]),
    .noc_out_valid_o (ep_out_valid[1]),
    .noc_out_ready_i (ep_out_ready[1]),
    .noc_in_flit_i   (ep_in_flit[1]),
    .noc_in_last_i   (ep_in_last[1]),
    .noc_in_valid_i  (ep_in_valid[1]),
    .noc_in_ready_o  (ep_in_ready[1])
  );

  for (genvar c = 0; c < na_pkg::CHANNELS; c++) begin : g_buf
    noc_buffer u_outbuffer (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_flit_i   (ep_out_flit[c]),
      .in_last_i   (ep_out_last[c]),
      .in_valid_i  (ep_out_valid[c]),
      .in_ready_o  (ep_out_ready[c]),
      .out_flit_o  (noc_out_flit_o[c]),
      .out_last_o  (noc_out_last_o[c]),
      .out_valid_o (noc_out_valid_o[c]),
      .out_ready_i (noc_out_ready_i[c])
    );

    noc_buffer u_inbuffer (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_flit_i   (noc_in_flit_i[c]),
      .in_last_i   (noc_in_last_i[c]),
      .in_valid_i  (noc_in_valid_i[c]),
      .in_ready_o  (noc_in_ready_o[c]),
      .out_flit_o  (ep_in_flit[c]),
      .out_last_o  (ep_in_last[c]),
      .out_valid_o (ep_in_valid[c]),
      .out_ready_i (ep_in_ready[c])
    );
  end

endmodule

//--- na_ctrl.sv
`timescale 1ns/1ps

module na_ctrl (
  input  logic                                                clk,
  input  logic                                                arst_n_i,

  input  logic [na_pkg::ADDR_WIDTH-1:0]                       wbs_adr_i,
  input  logic [na_pkg::FLIT_WIDTH-1:0]                       wbs_dat_i,
  input  logic                                                wbs_cyc_i,
  input  logic                                                wbs_stb_i,
  input  logic                                                wbs_we_i,
  output logic [na_pkg::FLIT_WIDTH-1:0]                       wbs_dat_o,
  output logic                                                wbs_ack_o,
  output logic                                                wbs_err_o,

  output logic [na_pkg::CHANNELS-1:0]                         send_push_o,
  output logic [na_pkg::CHANNELS-1:0]                         send_last_o,
  output logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] send_flit_o,
  output logic [na_pkg::CHANNELS-1:0]                         recv_pop_o,
  input  logic [na_pkg::CHANNELS-1:0]                         send_full_i,
  input  logic [na_pkg::CHANNELS-1:0][na_pkg::FLIT_WIDTH-1:0] recv_flit_i,
  input  logic [na_pkg::CHANNELS-1:0]                         recv_last_i,
  input  logic [na_pkg::CHANNELS-1:0]                         recv_empty_i,
  input  logic [na_pkg::CHANNELS-1:0][na_pkg::MP_CNT_W-1:0]   pkt_count_i,

  output logic [na_pkg::CHANNELS-1:0]                         irq_o
);

  na_pkg::na_region_e                 region;
  na_pkg::conf_reg_e                  conf_off;
  na_pkg::mp_reg_e                    mp_off;
  logic                               chan;
  logic                               req;
  logic                               acc_err;
  logic                               irqen_wr;
  logic [na_pkg::FLIT_WIDTH-1:0]      rdata;
  logic [na_pkg::FLIT_WIDTH-1:0]      wdata_q;
  logic [na_pkg::CHANNELS-1:0]        push;
  logic [na_pkg::CHANNELS-1:0]        last;
  logic [na_pkg::CHANNELS-1:0]        pop;
  logic [na_pkg::CHANNELS-1:0]        pkt_nz;
  logic [na_pkg::CHANNELS-1:0]        irqen_q;

  // New access only while no response is pending
  assign req      = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o & ~wbs_err_o;
  assign chan     = wbs_adr_i[na_pkg::CH_SEL_BIT];
  assign conf_off = na_pkg::conf_reg_e'(wbs_adr_i[3:0]);
  assign mp_off   = na_pkg::mp_reg_e'(wbs_adr_i[3:0]);

  assign send_flit_o = {na_pkg::CHANNELS{wdata_q}};

  always_comb begin
    case (wbs_adr_i[na_pkg::ADDR_WIDTH-1 -: 4])
      4'h0:    region = na_pkg::REGION_CONF;
      4'h1:    region = na_pkg::REGION_MP;
      default: region = na_pkg::REGION_NONE;
    endcase
  end

  always_comb begin
    acc_err  = 1'b0;
    irqen_wr = 1'b0;
    rdata    = '0;
    push     = '0;
    last     = '0;
    pop      = '0;
    case (region)
      na_pkg::REGION_CONF: begin
        case (conf_off)
          na_pkg::CONF_TILEID: begin
            rdata[15:0] = na_pkg::TILE_ID;
            acc_err     = wbs_we_i;
          end
          na_pkg::CONF_NCHANNELS: begin
            rdata[7:0] = 8'(na_pkg::CHANNELS);
            acc_err    = wbs_we_i;
          end
          na_pkg::CONF_IRQEN: begin
            rdata[na_pkg::CHANNELS-1:0] = irqen_q;
            irqen_wr                    = wbs_we_i;
          end
          default: ;
        endcase
      end
      na_pkg::REGION_MP: begin
        case (mp_off)
          na_pkg::MP_SEND, na_pkg::MP_SEND_LAST: begin
            if (wbs_we_i) begin
              acc_err    = send_full_i[chan];
              push[chan] = ~send_full_i[chan];
              last[chan] = (mp_off == na_pkg::MP_SEND_LAST);
            end
          end
          na_pkg::MP_RECV: begin
            acc_err   = wbs_we_i | recv_empty_i[chan];
            pop[chan] = ~wbs_we_i & ~recv_empty_i[chan];
            rdata     = recv_flit_i[chan];
          end
          na_pkg::MP_STATUS: begin
            acc_err                         = wbs_we_i;
            rdata[na_pkg::MP_CNT_W-1:0]     = pkt_count_i[chan];
            rdata[na_pkg::FLIT_WIDTH-1]     = recv_last_i[chan];
          end
          default: ;
        endcase
      end
      default: acc_err = 1'b1;
    endcase
  end

  always_comb begin
    for (int c = 0; c < na_pkg::CHANNELS; c++) begin
      pkt_nz[c] = (pkt_count_i[c] != '0);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wbs_ack_o   <= 1'b0;
      wbs_err_o   <= 1'b0;
      send_push_o <= '0;
      send_last_o <= '0;
      recv_pop_o  <= '0;
      irqen_q     <= '0;
      irq_o       <= '0;
    end else begin
      wbs_ack_o   <= req & ~acc_err;
      wbs_err_o   <= req & acc_err;
      send_push_o <= {na_pkg::CHANNELS{req}} & push;
      send_last_o <= {na_pkg::CHANNELS{req}} & last;
      recv_pop_o  <= {na_pkg::CHANNELS{req}} & pop;
      if (req & irqen_wr) begin
        irqen_q <= wbs_dat_i[na_pkg::CHANNELS-1:0];
      end
      irq_o <= pkt_nz & irqen_q;
    end
  end

  // Read data and write flit captured with the request
  always_ff @(posedge clk) begin
    if (req) begin
      wbs_dat_o <= rdata;
      wdata_q   <= wbs_dat_i;
    end
  end

endmodule

//--- mp_endpoint.sv
`timescale 1ns/1ps

module mp_endpoint (
  input  logic                          clk,
  input  logic                          arst_n_i,

  input  logic                          send_push_i,
  input  logic                          send_last_i,
  input  logic [na_pkg::FLIT_WIDTH-1:0] send_flit_i,
  output logic                          send_full_o,

  input  logic                          recv_pop_i,
  output logic [na_pkg::FLIT_WIDTH-1:0] recv_flit_o,
  output logic                          recv_last_o,
  output logic                          recv_empty_o,
  output logic [na_pkg::MP_CNT_W-1:0]   pkt_count_o,

  output logic [na_pkg::FLIT_WIDTH-1:0] noc_out_flit_o,
  output logic                          noc_out_last_o,
  output logic                          noc_out_valid_o,
  input  logic                          noc_out_ready_i,

  input  logic [na_pkg::FLIT_WIDTH-1:0] noc_in_flit_i,
  input  logic                          noc_in_last_i,
  input  logic                          noc_in_valid_i,
  output logic                          noc_in_ready_o
);

  logic [na_pkg::FLIT_WIDTH:0] send_mem [na_pkg::MP_DEPTH];
  logic [na_pkg::MP_PTR_W-1:0] send_wr;
  logic [na_pkg::MP_PTR_W-1:0] send_rd;
  logic [na_pkg::MP_CNT_W-1:0] send_fill;
  logic [na_pkg::MP_CNT_W-1:0] send_pkts;
  logic                        send_pop;

  logic [na_pkg::FLIT_WIDTH:0] recv_mem [na_pkg::MP_DEPTH];
  logic [na_pkg::MP_PTR_W-1:0] recv_wr;
  logic [na_pkg::MP_PTR_W-1:0] recv_rd;
  logic [na_pkg::MP_CNT_W-1:0] recv_fill;
  logic [na_pkg::MP_CNT_W-1:0] recv_pkts;
  logic                        recv_push;

  // Head goes out only once a whole packet sits in the queue
  assign noc_out_valid_o = (send_pkts != '0);
  assign send_pop        = noc_out_valid_o & noc_out_ready_i;
  assign send_full_o     = (send_fill == na_pkg::MP_FULL);

  assign {noc_out_last_o, noc_out_flit_o} = send_mem[send_rd];

  assign noc_in_ready_o = (recv_fill != na_pkg::MP_FULL);
  assign recv_push      = noc_in_valid_i & noc_in_ready_o;
  assign recv_empty_o   = (recv_fill == '0);
  assign pkt_count_o    = recv_pkts;

  assign {recv_last_o, recv_flit_o} = recv_mem[recv_rd];

  always_ff @(posedge clk) begin
    if (send_push_i) begin
      send_mem[send_wr] <= {send_last_i, send_flit_i};
    end
    if (recv_push) begin
      recv_mem[recv_wr] <= {noc_in_last_i, noc_in_flit_i};
    end
  end

  // Send queue
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      send_wr   <= '0;
      send_rd   <= '0;
      send_fill <= '0;
      send_pkts <= '0;
    end else begin
      if (send_push_i) begin
        send_wr <= send_wr + 1'b1;
      end
      if (send_pop) begin
        send_rd <= send_rd + 1'b1;
      end
      case ({send_push_i, send_pop})
        2'b10:   send_fill <= send_fill + 1'b1;
        2'b01:   send_fill <= send_fill - 1'b1;
        default: ;
      endcase
      case ({send_push_i & send_last_i, send_pop & noc_out_last_o})
        2'b10:   send_pkts <= send_pkts + 1'b1;
        2'b01:   send_pkts <= send_pkts - 1'b1;
        default: ;
      endcase
    end
  end

  // Receive queue
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      recv_wr   <= '0;
      recv_rd   <= '0;
      recv_fill <= '0;
      recv_pkts <= '0;
    end else begin
      if (recv_push) begin
        recv_wr <= recv_wr + 1'b1;
      end
      if (recv_pop_i) begin
        recv_rd <= recv_rd + 1'b1;
      end
      case ({recv_push, recv_pop_i})
        2'b10:   recv_fill <= recv_fill + 1'b1;
        2'b01:   recv_fill <= recv_fill - 1'b1;
        default: ;
      endcase
      case ({recv_push & noc_in_last_i, recv_pop_i & recv_last_o})
        2'b10:   recv_pkts <= recv_pkts + 1'b1;
        2'b01:   recv_pkts <= recv_pkts - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- noc_buffer.sv
`timescale 1ns/1ps

module noc_buffer (
  input  logic                          clk,
  input  logic                          arst_n_i,

  input  logic [na_pkg::FLIT_WIDTH-1:0] in_flit_i,
  input  logic                          in_last_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,

  output logic [na_pkg::FLIT_WIDTH-1:0] out_flit_o,
  output logic                          out_last_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i
);

  // Entry holds last bit on top of the flit
  logic [na_pkg::FLIT_WIDTH:0]  mem [na_pkg::BUF_DEPTH];
  logic [na_pkg::BUF_PTR_W-1:0] wr_ptr;
  logic [na_pkg::BUF_PTR_W-1:0] rd_ptr;
  logic [na_pkg::BUF_CNT_W-1:0] fill;
  logic                         push;
  logic                         pop;

  assign in_ready_o  = (fill != na_pkg::BUF_FULL);
  assign out_valid_o = (fill != '0);
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  assign {out_last_o, out_flit_o} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_last_i, in_flit_i};
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- na_pkg.sv
package na_pkg;

  localparam int FLIT_WIDTH = 32;
  localparam int CHANNELS   = 2;
  localparam int BUF_DEPTH  = 4;
  localparam int MP_DEPTH   = 16;
  localparam int ADDR_WIDTH = 24;

  localparam logic [15:0] TILE_ID = 16'd5;

  // Pointer and fill widths of the NoC buffer and the endpoint queues
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
  localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);
  localparam logic [BUF_CNT_W-1:0] BUF_FULL = BUF_CNT_W'(BUF_DEPTH);

  localparam int MP_PTR_W = $clog2(MP_DEPTH);
  localparam int MP_CNT_W = $clog2(MP_DEPTH + 1);
  localparam logic [MP_CNT_W-1:0] MP_FULL = MP_CNT_W'(MP_DEPTH);

  // Address bit that picks request or response channel
  localparam int CH_SEL_BIT = 4;

  // Decoded from address bits 23:20
  typedef enum logic [1:0] {
    REGION_CONF = 2'd0,
    REGION_MP   = 2'd1,
    REGION_NONE = 2'd2
  } na_region_e;

  typedef enum logic [3:0] {
    CONF_TILEID    = 4'h0,
    CONF_NCHANNELS = 4'h4,
    CONF_IRQEN     = 4'h8
  } conf_reg_e;

  typedef enum logic [3:0] {
    MP_SEND      = 4'h0,
    MP_SEND_LAST = 4'h4,
    MP_RECV      = 4'h8,
    MP_STATUS    = 4'hC
  } mp_reg_e;

endpackage
